/* files.f */
+incdir+testbench
src/hostctl_pkg.sv
src/rx_word_if.sv
src/rx_beat_tracker.sv
src/frame_cmd_matcher.sv
src/host_stall_ctrl.sv
src/hostctl_top.sv
testbench/tb_hostctl.sv

/* src/frame_cmd_matcher.sv */
// compares the first CMD_WORDS words of each frame with a fixed pattern
// every command word needs all four keep bits set
// frames shorter than CMD_WORDS never hit, words after the command are ignored
module frame_cmd_matcher #(
  parameter logic [hostctl_pkg::CMD_W-1:0] MATCH_PATTERN = '0
) (
  input  logic    CPUCLK,
  input  logic    bus_struct_reset,
  rx_word_if.sink beat,
  output logic    cmd_hit   // one cycle after the last beat of a matching frame
);

  hostctl_pkg::rx_word_t exp_word;     // pattern slice for this beat's position
  logic                  in_cmd;       // beat lies inside the command words
  logic                  word_ok;
  logic                  flag_in;      // match state before this beat
  logic                  flag_now;     // match state including this beat
  logic                  long_enough;  // frame reached the last command word
  logic                  match_flag;   // still matching, carried across beats

  //////////////////////////////////////////////////////////////////////////////
  // per-beat compare
  //////////////////////////////////////////////////////////////////////////////

  // word k of the frame sits in bits 32k+31..32k of the pattern
  always_comb begin
    exp_word = '0;
    for (int k = 0; k < hostctl_pkg::CMD_WORDS; k++) begin
      if (beat.beat_idx == k) begin
        exp_word = MATCH_PATTERN[k*hostctl_pkg::RX_DATA_W +: hostctl_pkg::RX_DATA_W];
      end
    end
  end

  assign in_cmd      = beat.beat_idx < hostctl_pkg::CMD_WORDS;
  assign word_ok     = (beat.beat_data == exp_word) && (&beat.beat_keep);
  assign flag_in     = (beat.beat_idx == '0) ? 1'b1 : match_flag;  // fresh frame
  assign flag_now    = in_cmd ? (flag_in & word_ok) : flag_in;
  assign long_enough = beat.beat_idx >= (hostctl_pkg::CMD_WORDS - 1);

  //////////////////////////////////////////////////////////////////////////////
  // frame state and hit
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      match_flag <= 1'b0;
      cmd_hit    <= 1'b0;
    end else begin
      // gaps leave the flag alone
      if (beat.beat_valid) begin
        match_flag <= flag_now;
      end
      cmd_hit <= beat.beat_valid & beat.beat_last & flag_now & long_enough;
    end
  end

endmodule

/* src/host_stall_ctrl.sv */
// slow-down request handling, holds the core for SLOW_CYCLES+1 cycles
// the hold only starts after the trace path has stalled the core once
// requests are dropped while a slow-down is pending or running
module host_stall_ctrl (
  input  logic CPUCLK,
  input  logic bus_struct_reset,
  input  logic slow_req,        // pulse from the slow-down matcher
  input  logic trace_stall,     // stall from the trace packetizer
  output logic host_stall,
  output logic external_stall   // to the core
);

  hostctl_pkg::stall_state_t         state;
  hostctl_pkg::stall_state_t         state_nxt;
  logic [hostctl_pkg::SLOW_CNT_W-1:0] slow_cnt;
  logic                               cnt_done;

  //////////////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      state <= hostctl_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      hostctl_pkg::ST_IDLE: begin
        if (slow_req) begin
          state_nxt = hostctl_pkg::ST_WAIT_TRACE;
        end
      end
      hostctl_pkg::ST_WAIT_TRACE: begin
        // packetizer must have stalled at least once
        if (trace_stall) begin
          state_nxt = hostctl_pkg::ST_COUNT;
        end
      end
      hostctl_pkg::ST_COUNT: begin
        if (cnt_done) begin
          state_nxt = hostctl_pkg::ST_IDLE;
        end
      end
      default: state_nxt = hostctl_pkg::ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////////
  // hold counter
  //////////////////////////////////////////////////////////////////////////////

  // 0 on entry to ST_COUNT, leaves after the cycle that shows SLOW_CYCLES
  assign cnt_done = slow_cnt >= hostctl_pkg::SLOW_CYCLES;

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      slow_cnt <= '0;
    end else if (state == hostctl_pkg::ST_IDLE) begin
      slow_cnt <= '0;
    end else if (state == hostctl_pkg::ST_COUNT) begin
      slow_cnt <= slow_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // stall merge
  //////////////////////////////////////////////////////////////////////////////

  assign host_stall     = (state == hostctl_pkg::ST_COUNT);
  assign external_stall = trace_stall | host_stall;  // either source halts the core

endmodule

/* src/hostctl_pkg.sv */
// shared constants and types for the host-control receive path
// command patterns hold word 0 of the frame in bits 31:0, word 4 in bits 159:128
// the slow-down count is fixed at build time, no runtime register
package hostctl_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // receive stream geometry
  //////////////////////////////////////////////////////////////////////////////

  localparam int RX_DATA_W  = 32;  // one AXI-stream word from the MAC
  localparam int RX_KEEP_W  = 4;   // byte keep, one bit per byte
  localparam int CMD_WORDS  = 5;   // leading words that carry a command
  localparam int CMD_W      = CMD_WORDS * RX_DATA_W;
  localparam int BEAT_IDX_W = 3;   // saturates at CMD_WORDS

  typedef logic [RX_DATA_W-1:0] rx_word_t;
  typedef logic [RX_KEEP_W-1:0] rx_keep_t;

  //////////////////////////////////////////////////////////////////////////////
  // command frames
  //////////////////////////////////////////////////////////////////////////////

  // word 4: "igin", word 3: "rt" + ethertype 005c,
  // words 2..1: source MAC, words 1..0: destination MAC
  localparam logic [CMD_W-1:0] TRIGGER_CMD =
    160'h6e69_6769_7274_005c_8f54_0000_1654_4502_1111_6843;

  // same header, payload spells "slowme" in wire order
  localparam logic [CMD_W-1:0] SLOWDOWN_CMD =
    160'h656d_776f_6c73_005c_8f54_0000_1654_4502_1111_6843;

  //////////////////////////////////////////////////////////////////////////////
  // host stall
  //////////////////////////////////////////////////////////////////////////////

  localparam int SLOW_CNT_W = 11;
  // host_stall holds for SLOW_CYCLES+1 cycles
  localparam logic [SLOW_CNT_W-1:0] SLOW_CYCLES = 11'd2000;

  typedef enum logic [1:0] {
    ST_IDLE,        // no request pending
    ST_WAIT_TRACE,  // request seen, waiting for a trace stall
    ST_COUNT        // core held by the host
  } stall_state_t;

endpackage

/* src/hostctl_top.sv */
// host-control receive path, trigger and slow-down commands from Ethernet
// rx_* is the MAC receive stream, always accepted
// trace_stall comes from the trace packetizer, external_stall goes to the core
module hostctl_top (
  input  logic                  CPUCLK,
  input  logic                  bus_struct_reset,
  input  hostctl_pkg::rx_word_t rx_data,
  input  hostctl_pkg::rx_keep_t rx_keep,
  input  logic                  rx_valid,
  input  logic                  rx_last,
  input  logic                  trace_stall,
  output logic                  ila_trigger,     // one-cycle pulse per trigger frame
  output logic                  host_stall,
  output logic                  external_stall
);

  logic slow_req;  // slow-down frame seen

  rx_word_if rx_beat ();

  //////////////////////////////////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////////////////////////////////

  rx_beat_tracker u_tracker (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .rx_data          (rx_data),
    .rx_keep          (rx_keep),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .beat             (rx_beat.source)
  );

  //////////////////////////////////////////////////////////////////////////////
  // command matchers
  //////////////////////////////////////////////////////////////////////////////

  frame_cmd_matcher #(
    .MATCH_PATTERN (hostctl_pkg::TRIGGER_CMD)
  ) u_trig_match (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .beat             (rx_beat.sink),
    .cmd_hit          (ila_trigger)
  );

  frame_cmd_matcher #(
    .MATCH_PATTERN (hostctl_pkg::SLOWDOWN_CMD)
  ) u_slow_match (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .beat             (rx_beat.sink),
    .cmd_hit          (slow_req)
  );

  //////////////////////////////////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////////////////////////////////

  host_stall_ctrl u_stall (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .slow_req         (slow_req),
    .trace_stall      (trace_stall),
    .host_stall       (host_stall),
    .external_stall   (external_stall)
  );

endmodule

/* src/rx_beat_tracker.sv */
// registers each receive beat and tags it with its word position in the frame
// stream is always accepted, the MAC has no back-pressure here
// first valid beat after reset and after every last beat gets index 0
module rx_beat_tracker (
  input  logic                  CPUCLK,
  input  logic                  bus_struct_reset,
  input  hostctl_pkg::rx_word_t rx_data,
  input  hostctl_pkg::rx_keep_t rx_keep,
  input  logic                  rx_valid,
  input  logic                  rx_last,
  rx_word_if.source             beat
);

  logic [hostctl_pkg::BEAT_IDX_W-1:0] next_idx;  // slot the next valid beat takes
  logic [hostctl_pkg::BEAT_IDX_W-1:0] idx_inc;   // next_idx advanced, saturating

  //////////////////////////////////////////////////////////////////////////////
  // word position
  //////////////////////////////////////////////////////////////////////////////

  // stop counting once past the command words, the matchers
  // only care whether a beat is inside or beyond the command
  always_comb begin
    if (next_idx >= hostctl_pkg::CMD_WORDS) begin
      idx_inc = next_idx;
    end else begin
      idx_inc = next_idx + 1'b1;
    end
  end

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      next_idx <= '0;
    end else if (rx_valid) begin
      if (rx_last) begin
        next_idx <= '0;  // new frame follows
      end else begin
        next_idx <= idx_inc;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // beat register
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      beat.beat_valid <= 1'b0;
      beat.beat_idx   <= '0;
    end else begin
      beat.beat_valid <= rx_valid;  // gaps pass through as invalid cycles
      if (rx_valid) begin
        beat.beat_idx <= next_idx;
      end
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge CPUCLK) begin
    if (rx_valid) begin
      beat.beat_data <= rx_data;
      beat.beat_keep <= rx_keep;
      beat.beat_last <= rx_last;
    end
  end

endmodule

/* src/rx_word_if.sv */
// one registered receive beat, no handshake
// a beat exists only in cycles with beat_valid high, gaps carry nothing
// beat_idx is the word position in the frame, saturating at CMD_WORDS
interface rx_word_if;

  logic                                 beat_valid;
  hostctl_pkg::rx_word_t                beat_data;
  hostctl_pkg::rx_keep_t                beat_keep;
  logic                                 beat_last;   // frame ends with this beat
  logic [hostctl_pkg::BEAT_IDX_W-1:0]   beat_idx;

  // driven by the beat tracker
  modport source (
    output beat_valid,
    output beat_data,
    output beat_keep,
    output beat_last,
    output beat_idx
  );

  // read by every command matcher
  modport sink (
    input beat_valid,
    input beat_data,
    input beat_keep,
    input beat_last,
    input beat_idx
  );

endinterface

/* testbench/tb_frame_tasks.svh */
// frame building, stream driving and the directed tests
// included inside tb_hostctl, works on its signals and compare tasks
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

hostctl_pkg::rx_word_t frame_words[$];  // frame waiting to be driven
hostctl_pkg::rx_keep_t frame_keeps[$];

task automatic apply_reset();
  bus_struct_reset = 1'b1;
  repeat (10) @(negedge CPUCLK);
  bus_struct_reset = 1'b0;
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(negedge CPUCLK);
    rx_valid = 1'b0;
    rx_last  = 1'b0;
  end
endtask

// n_cmd pattern words, then n_extra random trailing words
task automatic build_frame(input logic [hostctl_pkg::CMD_W-1:0] pattern,
                           input int n_cmd, input int n_extra);
  frame_words.delete();
  frame_keeps.delete();
  for (int k = 0; k < n_cmd; k++) begin
    frame_words.push_back(pattern[k*32 +: 32]);
    frame_keeps.push_back(4'hf);
  end
  repeat (n_extra) begin
    frame_words.push_back($random(seed));
    frame_keeps.push_back(4'hf);
  end
endtask

task automatic build_random_frame(input int n);
  hostctl_pkg::rx_word_t w;
  build_frame('0, 0, n);
  w = frame_words[0];
  if (w == hostctl_pkg::TRIGGER_CMD[31:0]) begin
    frame_words[0] = ~w;  // both commands share word 0
  end
endtask

// kind 1 is a trigger, kind 2 a slow-down, anything else no pulse
task automatic drive_frame(input int max_gap, input int kind);
  int gap;
  foreach (frame_words[i]) begin
    gap = (max_gap > 0) ? ($unsigned($random(seed)) % (max_gap + 1)) : 0;
    idle_cycles(gap);
    @(negedge CPUCLK);
    rx_valid = 1'b1;
    rx_data  = frame_words[i];
    rx_keep  = frame_keeps[i];
    rx_last  = (i == frame_words.size() - 1);
  end
  if (kind == 1) begin
    exp_trig_q.push_back(cyc + 2);  // two edges after the last beat
  end else if (kind == 2) begin
    exp_slow_q.push_back(cyc + 2);
  end
endtask

task automatic match_pulses(input string what);
  idle_cycles(4);  // let the pipeline drain
  if (got_trig_q.size() != exp_trig_q.size()) begin
    $display("%0t: %s gave %0d trigger pulses where %0d were due", $time, what,
             got_trig_q.size(), exp_trig_q.size());
    check_errs++;
  end else begin
    foreach (exp_trig_q[i]) check_cycle("ila_trigger", exp_trig_q[i], got_trig_q[i]);
  end
  if (got_slow_q.size() != exp_slow_q.size()) begin
    $display("%0t: %s gave %0d slow-down requests where %0d were due", $time, what,
             got_slow_q.size(), exp_slow_q.size());
    check_errs++;
  end else begin
    foreach (exp_slow_q[i]) check_cycle("slow_req", exp_slow_q[i], got_slow_q[i]);
  end
  exp_trig_q.delete();
  exp_slow_q.delete();
  got_trig_q.delete();
  got_slow_q.delete();
endtask

task automatic pulse_trace_stall();
  @(negedge CPUCLK);
  trace_stall = 1'b1;
  @(negedge CPUCLK);
  trace_stall = 1'b0;
endtask

task automatic expect_stall_low(input int n);
  repeat (n) begin
    @(negedge CPUCLK);
    check_bit("host_stall", 1'b0, host_stall);
  end
endtask

// counts falling edges with host_stall high, starting at the current one
task automatic measure_stall(output int run);
  int waited;
  waited = 0;
  run    = 0;
  while (!host_stall && waited < 20) begin
    @(negedge CPUCLK);
    waited++;
  end
  if (!host_stall) begin
    $display("%0t: host_stall did not rise within 20 cycles", $time);
    timeout_errs++;
  end else begin
    while (host_stall && run < 2047) begin
      run++;
      @(negedge CPUCLK);
    end
    if (host_stall) begin
      $display("%0t: host_stall still high after %0d cycles", $time, run);
      timeout_errs++;
    end
  end
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////

task automatic trigger_frame_test();
  build_frame(hostctl_pkg::TRIGGER_CMD, 5, 1);
  drive_frame(0, 1);
  match_pulses("trigger frame");
  expect_stall_low(10);
endtask

// altered word, partial keep and four-word frames, for both commands
task automatic bad_frame_test();
  logic [hostctl_pkg::CMD_W-1:0] pat;
  for (int c = 0; c < 6; c++) begin
    pat = (c % 2 == 0) ? hostctl_pkg::TRIGGER_CMD : hostctl_pkg::SLOWDOWN_CMD;
    build_frame(pat, (c >= 4) ? 4 : 5, (c >= 4) ? 0 : 1);
    if (c < 2) begin
      frame_words[c + 2] = frame_words[c + 2] ^ 32'h0000_0100;
    end else if (c < 4) begin
      frame_keeps[c + 1] = 4'b0111;
    end
    drive_frame(0, 0);
    idle_cycles(2);
  end
  match_pulses("bad frames");
  pulse_trace_stall();  // a pending request would start the hold now
  expect_stall_low(20);
endtask

task automatic slow_down_test();
  int run;
  build_frame(hostctl_pkg::SLOWDOWN_CMD, 5, 0);
  drive_frame(0, 2);
  match_pulses("slow-down frame");
  expect_stall_low(50);
  pulse_trace_stall();
  measure_stall(run);
  check_count("host_stall cycles", stall_cnt_t'(hostctl_pkg::SLOW_CYCLES + 1), stall_cnt_t'(run));
  expect_stall_low(10);
endtask

task automatic slow_during_count_test();
  int run;
  build_frame(hostctl_pkg::SLOWDOWN_CMD, 5, 2);
  drive_frame(0, 2);
  idle_cycles(3);
  pulse_trace_stall();
  fork
    measure_stall(run);
    begin
      idle_cycles(100);  // well inside the hold
      build_frame(hostctl_pkg::SLOWDOWN_CMD, 5, 0);
      drive_frame(0, 2);
      idle_cycles(1);
    end
  join
  check_count("host_stall cycles", stall_cnt_t'(hostctl_pkg::SLOW_CYCLES + 1), stall_cnt_t'(run));
  match_pulses("slow-down during hold");
  expect_stall_low(100);
  pulse_trace_stall();  // second request must have been dropped
  expect_stall_low(20);
endtask

task automatic mixed_stream_test();
  int kind;
  int n_extra;
  for (int i = 0; i < 16; i++) begin
    kind    = $unsigned($random(seed)) % 3;
    n_extra = $unsigned($random(seed)) % 4;
    case (kind)
      1:       build_frame(hostctl_pkg::TRIGGER_CMD, 5, n_extra);
      2:       build_frame(hostctl_pkg::SLOWDOWN_CMD, 5, n_extra);
      default: build_random_frame(1 + $unsigned($random(seed)) % 8);
    endcase
    drive_frame(3, kind);
  end
  match_pulses("mixed stream");
  check_bit("host_stall", 1'b0, host_stall);  // trace path never stalled
endtask

`endif

/* testbench/tb_hostctl.sv */
// directed testbench for hostctl_top
// inputs change on the falling edge, pulses are sampled on the rising edge
// slow-down detection is observed on the internal slow_req of the DUT
module tb_hostctl;

  typedef logic [hostctl_pkg::SLOW_CNT_W-1:0] stall_cnt_t;

  logic                  CPUCLK;
  logic                  bus_struct_reset;
  hostctl_pkg::rx_word_t rx_data;
  hostctl_pkg::rx_keep_t rx_keep;
  logic                  rx_valid;
  logic                  rx_last;
  logic                  trace_stall;
  logic                  ila_trigger;
  logic                  host_stall;
  logic                  external_stall;

  integer seed;
  int     check_errs   = 0;
  int     timeout_errs = 0;
  int     cyc          = 0;  // rising edges seen so far
  int     exp_trig_q[$];     // cycle in which each pulse is due
  int     exp_slow_q[$];
  int     got_trig_q[$];
  int     got_slow_q[$];

  hostctl_top u_dut (
    .CPUCLK           (CPUCLK),
    .bus_struct_reset (bus_struct_reset),
    .rx_data          (rx_data),
    .rx_keep          (rx_keep),
    .rx_valid         (rx_valid),
    .rx_last          (rx_last),
    .trace_stall      (trace_stall),
    .ila_trigger      (ila_trigger),
    .host_stall       (host_stall),
    .external_stall   (external_stall)
  );

  initial begin
    CPUCLK = 1'b0;
    forever #4 CPUCLK = ~CPUCLK;
  end

  //////////////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %b actual %b", $time, name, exp, act);
      check_errs++;
    end
  endtask

  task automatic check_count(input string name, input stall_cnt_t exp, input stall_cnt_t act);
    if (act !== exp) begin
      $display("Error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      check_errs++;
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error at %0t: %s expected cycle %0d actual cycle %0d", $time, name, exp, act);
      check_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // monitor
  //////////////////////////////////////////////////////////////////////////////

  // reads pre-edge values, so no race with the DUT registers
  always @(posedge CPUCLK) begin
    cyc <= cyc + 1;
    if (!bus_struct_reset) begin
      if (ila_trigger) begin
        got_trig_q.push_back(cyc);
      end
      if (u_dut.slow_req) begin
        got_slow_q.push_back(cyc);
      end
      check_bit("external_stall", trace_stall | host_stall, external_stall);
    end
  end

  `include "tb_frame_tasks.svh"

  //////////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    seed             = 32'hf6e1_5a4c;
    bus_struct_reset = 1'b1;
    rx_data          = '0;
    rx_keep          = '0;
    rx_valid         = 1'b0;
    rx_last          = 1'b0;
    trace_stall      = 1'b0;
    apply_reset();
    trigger_frame_test();
    bad_frame_test();
    slow_down_test();
    slow_during_count_test();
    mixed_stream_test();
    $display("Run finished with %0d check errors and %0d timeouts", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
